//--- design/llc_cfg_consts.svh
////////////////////////////////////////
// LLC_NUM_LINES must equal 2**LLC_INDEX_LEN
// LLC_SET_ASSO may not exceed LLC_REG_WIDTH
////////////////////////////////////////
`ifndef LLC_CFG_CONSTS_SVH
`define LLC_CFG_CONSTS_SVH

// Cache geometry
`define LLC_SET_ASSO        8
`define LLC_INDEX_LEN       4
`define LLC_NUM_LINES       16

// Register port
`define LLC_REG_WIDTH       32
`define LLC_REG_ADDR_LEN    3
`define LLC_VERSION         32'h0001_0003

// Descriptor buffering between flush FSM and cache
`define LLC_DESC_FIFO_DEPTH 4

// Register indices
`define LLC_REG_SPM         0
`define LLC_REG_FLUSH       1
`define LLC_REG_FLUSHED     2
`define LLC_REG_SET_ASSO    3
`define LLC_REG_NUM_LINES   4
`define LLC_REG_VERSION     5

`endif

//--- design/llc_cfg_pkg.sv
////////////////////////////////////////
// Widths follow llc_cfg_consts.svh
////////////////////////////////////////
`default_nettype none

`include "llc_cfg_consts.svh"

package llc_cfg_pkg;

  // One bit per cache way
  typedef logic [`LLC_SET_ASSO-1:0]     way_mask_t;
  // Line index inside one way
  typedef logic [`LLC_INDEX_LEN-1:0]    line_idx_t;
  // Register word and register index
  typedef logic [`LLC_REG_WIDTH-1:0]    reg_data_t;
  typedef logic [`LLC_REG_ADDR_LEN-1:0] reg_addr_t;

  // Flush sequence, one way per pass through InitWay .. EndWay
  typedef enum logic [2:0] {
    FlushIdle,
    FlushWaitQuiet,
    FlushInitWay,
    FlushSend,
    FlushWaitDone,
    FlushEndWay
  } flush_state_e;

endpackage

`default_nettype wire

//--- design/llc_cfg_regs.sv
////////////////////////////////////////
// One request in flight; no access is taken while a flush runs
// Way masks read back zero-padded to the register width
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "llc_cfg_consts.svh"

module llc_cfg_regs (
  input  logic                  rst_ni,
  input  logic                  reset_i,
  // Request channel
  input  logic                  reg_req_valid_i,
  output logic                  reg_req_ready_o,
  input  logic                  reg_req_write_i,
  input  llc_cfg_pkg::reg_addr_t reg_req_addr_i,
  input  llc_cfg_pkg::reg_data_t reg_req_wdata_i,
  // Response channel
  output logic                  reg_rsp_valid_o,
  input  logic                  reg_rsp_ready_i,
  output llc_cfg_pkg::reg_data_t reg_rsp_rdata_o,
  output logic                  reg_rsp_err_o,
  // Flush controller side
  input  llc_cfg_pkg::way_mask_t flushed_d_i,
  input  logic                  flushed_load_i,
  input  logic                  flush_clear_i,
  input  logic                  cfg_busy_i,
  output llc_cfg_pkg::way_mask_t cfg_spm_o,
  output llc_cfg_pkg::way_mask_t cfg_flush_o,
  output llc_cfg_pkg::way_mask_t flushed_o,
  output logic                  cfg_written_o
);
  import llc_cfg_pkg::*;

  // Architectural registers
  way_mask_t cfg_spm_q;
  way_mask_t cfg_flush_q;
  way_mask_t flushed_q;
  // Response held until taken
  logic      rsp_valid_q;
  reg_data_t rsp_rdata_q;
  logic      rsp_err_q;
  logic      cfg_written_q;

  logic      req_fire;
  logic      addr_err;
  logic      wr_cfg;
  reg_data_t rd_data;

  // Blocked by a pending response and by a running flush
  assign reg_req_ready_o = !rsp_valid_q && !cfg_busy_i;
  assign req_fire        = reg_req_valid_i && reg_req_ready_o;

  // Past Version nothing exists, past CfgFlush everything is read-only
  assign addr_err = (reg_req_addr_i > reg_addr_t'(`LLC_REG_VERSION)) ||
                    (reg_req_write_i && (reg_req_addr_i > reg_addr_t'(`LLC_REG_FLUSH)));
  // Accepted write to CfgSpm or CfgFlush
  assign wr_cfg   = req_fire && reg_req_write_i && !addr_err;

  // Read decode with unmapped indices giving 0
  always_comb begin
    unique case (reg_req_addr_i)
      reg_addr_t'(`LLC_REG_SPM):       rd_data = reg_data_t'(cfg_spm_q);
      reg_addr_t'(`LLC_REG_FLUSH):     rd_data = reg_data_t'(cfg_flush_q);
      reg_addr_t'(`LLC_REG_FLUSHED):   rd_data = reg_data_t'(flushed_q);
      reg_addr_t'(`LLC_REG_SET_ASSO):  rd_data = reg_data_t'(`LLC_SET_ASSO);
      reg_addr_t'(`LLC_REG_NUM_LINES): rd_data = reg_data_t'(`LLC_NUM_LINES);
      reg_addr_t'(`LLC_REG_VERSION):   rd_data = reg_data_t'(`LLC_VERSION);
      default:                         rd_data = '0;
    endcase
  end

  ////////////////////////////////////////
  // Control state
  ////////////////////////////////////////
  always_ff @(posedge rst_ni) begin
    if (reset_i) begin
      cfg_spm_q     <= '0;
      cfg_flush_q   <= '0;
      flushed_q     <= '0;
      rsp_valid_q   <= 1'b0;
      cfg_written_q <= 1'b0;
    end else begin
      // Kicks the flush FSM one cycle after acceptance
      cfg_written_q <= wr_cfg;
      if (req_fire) begin
        rsp_valid_q <= 1'b1;
      end else if (reg_rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
      if (wr_cfg && (reg_req_addr_i == reg_addr_t'(`LLC_REG_SPM))) begin
        cfg_spm_q <= way_mask_t'(reg_req_wdata_i);
      end
      // Flush side only acts while the FSM owns the registers
      if (wr_cfg && (reg_req_addr_i == reg_addr_t'(`LLC_REG_FLUSH))) begin
        cfg_flush_q <= way_mask_t'(reg_req_wdata_i);
      end else if (flush_clear_i && cfg_busy_i) begin
        cfg_flush_q <= '0;
      end
      if (flushed_load_i && cfg_busy_i) begin
        flushed_q <= flushed_d_i;
      end
    end
  end

  // Response payload captured with the request
  always_ff @(posedge rst_ni) begin
    if (req_fire) begin
      rsp_rdata_q <= reg_req_write_i ? '0 : rd_data;
      rsp_err_q   <= addr_err;
    end
  end

  assign reg_rsp_valid_o = rsp_valid_q;
  assign reg_rsp_rdata_o = rsp_rdata_q;
  assign reg_rsp_err_o   = rsp_err_q;
  assign cfg_spm_o       = cfg_spm_q;
  assign cfg_flush_o     = cfg_flush_q;
  assign flushed_o       = flushed_q;
  assign cfg_written_o   = cfg_written_q;

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////
  // Config write reaches the flush FSM only while it is idle
  a_no_write_busy: assert property (@(posedge rst_ni) disable iff (reset_i)
    cfg_written_o |-> !cfg_busy_i)
    else $error("config write landed during flush");

endmodule

`default_nettype wire

//--- design/llc_flush_ctrl.sv
////////////////////////////////////////
// Flushes one way at a time, lowest way first
// Expects exactly one flush_done_i per emitted descriptor
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module llc_flush_ctrl (
  input  logic                  rst_ni,
  input  logic                  reset_i,
  // Register side
  input  logic                  cfg_written_i,
  input  llc_cfg_pkg::way_mask_t cfg_spm_i,
  input  llc_cfg_pkg::way_mask_t cfg_flush_i,
  input  llc_cfg_pkg::way_mask_t flushed_i,
  output llc_cfg_pkg::way_mask_t flushed_d_o,
  output logic                  flushed_load_o,
  output logic                  flush_clear_o,
  output logic                  cfg_busy_o,
  // Cache side
  input  logic                  quiescent_i,
  input  logic                  flush_done_i,
  output logic                  isolate_o,
  // Descriptor push into the FIFO
  output logic                  push_valid_o,
  input  logic                  push_ready_i,
  output llc_cfg_pkg::line_idx_t push_line_o,
  output llc_cfg_pkg::way_mask_t push_way_o
);
  import llc_cfg_pkg::*;

  flush_state_e state_q, state_d;
  // Ways still to flush in this sequence
  way_mask_t    to_flush_q, to_flush_d;
  // One-hot lowest way of to_flush_q
  way_mask_t    way_sel;
  // Next line to send, and done pulses seen for this way
  line_idx_t    send_cnt_q;
  line_idx_t    recv_cnt_q;
  logic         cnt_clear;
  logic         recv_en;
  logic         push_fire;

  // x & -x keeps only the lowest set bit
  assign way_sel   = to_flush_q & way_mask_t'(~to_flush_q + way_mask_t'(1));
  assign push_fire = push_valid_o && push_ready_i;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////
  always_comb begin
    state_d        = state_q;
    to_flush_d     = to_flush_q;
    flushed_d_o    = flushed_i;
    flushed_load_o = 1'b0;
    flush_clear_o  = 1'b0;
    cnt_clear      = 1'b0;
    recv_en        = 1'b0;
    unique case (state_q)
      FlushIdle: begin
        if (cfg_written_i) begin
          state_d = FlushWaitQuiet;
        end
      end
      FlushWaitQuiet: begin
        // Cache isolated, no traffic left inside
        if (quiescent_i) begin
          state_d = FlushInitWay;
        end
      end
      FlushInitWay: begin
        // Explicit flush request wins over SPM reconfiguration
        if (|cfg_flush_i) begin
          to_flush_d = cfg_flush_i & ~flushed_i;
        end else begin
          to_flush_d     = cfg_spm_i & ~flushed_i;
          // Ways released from SPM are no longer flushed
          flushed_d_o    = cfg_spm_i & flushed_i;
          flushed_load_o = 1'b1;
        end
        if (to_flush_d == '0) begin
          flush_clear_o = 1'b1;
          state_d       = FlushIdle;
        end else begin
          cnt_clear = 1'b1;
          state_d   = FlushSend;
        end
      end
      FlushSend: begin
        // Early completions already count here
        recv_en = flush_done_i;
        if (push_fire && (send_cnt_q == '1)) begin
          state_d = FlushWaitDone;
        end
      end
      FlushWaitDone: begin
        recv_en = flush_done_i;
        if (flush_done_i && (recv_cnt_q == '1)) begin
          state_d = FlushEndWay;
        end
      end
      FlushEndWay: begin
        flushed_load_o = 1'b1;
        if (to_flush_q == way_sel) begin
          // Flushed settles to the SPM ways after the last way
          flushed_d_o   = cfg_spm_i;
          flush_clear_o = 1'b1;
          to_flush_d    = '0;
          state_d       = FlushIdle;
        end else begin
          flushed_d_o = flushed_i | way_sel;
          to_flush_d  = to_flush_q & ~way_sel;
          state_d     = FlushInitWay;
        end
      end
      default: state_d = FlushIdle;
    endcase
  end

  ////////////////////////////////////////
  // State and counters
  ////////////////////////////////////////
  always_ff @(posedge rst_ni) begin
    if (reset_i) begin
      state_q    <= FlushIdle;
      to_flush_q <= '0;
      send_cnt_q <= '0;
      recv_cnt_q <= '0;
    end else begin
      state_q    <= state_d;
      to_flush_q <= to_flush_d;
      if (cnt_clear) begin
        send_cnt_q <= '0;
        recv_cnt_q <= '0;
      end else begin
        // Both wrap to 0 after line 15
        if (push_fire) begin
          send_cnt_q <= send_cnt_q + line_idx_t'(1);
        end
        if (recv_en) begin
          recv_cnt_q <= recv_cnt_q + line_idx_t'(1);
        end
      end
    end
  end

  assign isolate_o    = (state_q != FlushIdle);
  assign cfg_busy_o   = (state_q != FlushIdle);
  assign push_valid_o = (state_q == FlushSend);
  assign push_line_o  = send_cnt_q;
  assign push_way_o   = way_sel;

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////
  // Completions never outrun the descriptors sent for this way
  a_done_after_send: assert property (@(posedge rst_ni) disable iff (reset_i)
    ((state_q == FlushSend) && flush_done_i) |-> (recv_cnt_q != send_cnt_q))
    else $error("flush_done_i ahead of the descriptors sent");

  // Cache completions only while this way is in flight
  a_done_in_flight: assert property (@(posedge rst_ni) disable iff (reset_i)
    flush_done_i |-> (state_q inside {FlushSend, FlushWaitDone}))
    else $error("flush_done_i outside a running flush");

endmodule

`default_nettype wire

//--- design/llc_flush_desc_fifo.sv
////////////////////////////////////////
// depth must be at least 2
// Output comes straight from storage, one cycle after the push
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "llc_cfg_consts.svh"

module llc_flush_desc_fifo #(
  parameter int unsigned depth = `LLC_DESC_FIFO_DEPTH
) (
  input  logic                  rst_ni,
  input  logic                  reset_i,
  // Push side from the flush FSM
  input  logic                  push_valid_i,
  output logic                  push_ready_o,
  input  llc_cfg_pkg::line_idx_t push_line_i,
  input  llc_cfg_pkg::way_mask_t push_way_i,
  // Descriptor side towards the cache
  output logic                  desc_valid_o,
  input  logic                  desc_ready_i,
  output llc_cfg_pkg::line_idx_t desc_index_o,
  output llc_cfg_pkg::way_mask_t desc_way_o
);
  import llc_cfg_pkg::*;

  localparam int unsigned ptr_w = $clog2(depth);
  localparam int unsigned cnt_w = $clog2(depth + 1);

  // Descriptor storage
  line_idx_t        mem_line [depth];
  way_mask_t        mem_way  [depth];
  logic [ptr_w-1:0] wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             full, empty;
  logic             push_fire, pop_fire;

  assign full      = (count_q == cnt_w'(depth));
  assign empty     = (count_q == '0);
  assign push_fire = push_valid_i && !full;
  assign pop_fire  = desc_valid_o && desc_ready_i;

  always_ff @(posedge rst_ni) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap at depth, not at a power of two
      if (push_fire) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_fire && !pop_fire) begin
        count_q <= count_q + 1'b1;
      end else if (pop_fire && !push_fire) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge rst_ni) begin
    if (push_fire) begin
      mem_line[wr_ptr_q] <= push_line_i;
      mem_way[wr_ptr_q]  <= push_way_i;
    end
  end

  assign push_ready_o = !full;
  assign desc_valid_o = !empty;
  assign desc_index_o = mem_line[rd_ptr_q];
  assign desc_way_o   = mem_way[rd_ptr_q];

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////
  // Producer holds its entry while the FIFO is full
  a_push_held: assert property (@(posedge rst_ni) disable iff (reset_i)
    (push_valid_i && full) |=> (push_valid_i && $stable(push_line_i) && $stable(push_way_i)))
    else $error("descriptor dropped while FIFO full");

  a_desc_stable: assert property (@(posedge rst_ni) disable iff (reset_i)
    (desc_valid_o && !desc_ready_i) |=>
      (desc_valid_o && $stable(desc_index_o) && $stable(desc_way_o)))
    else $error("descriptor changed under back-pressure");

endmodule

`default_nettype wire

//--- design/llc_cfg_top.sv
////////////////////////////////////////
// Register port and cache port share one clock
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module llc_cfg_top (
  input  logic                  rst_ni,
  input  logic                  reset_i,
  // Register request and response
  input  logic                  reg_req_valid_i,
  output logic                  reg_req_ready_o,
  input  logic                  reg_req_write_i,
  input  llc_cfg_pkg::reg_addr_t reg_req_addr_i,
  input  llc_cfg_pkg::reg_data_t reg_req_wdata_i,
  output logic                  reg_rsp_valid_o,
  input  logic                  reg_rsp_ready_i,
  output llc_cfg_pkg::reg_data_t reg_rsp_rdata_o,
  output logic                  reg_rsp_err_o,
  // Flush descriptors to the cache
  output logic                  desc_valid_o,
  input  logic                  desc_ready_i,
  output llc_cfg_pkg::line_idx_t desc_index_o,
  output llc_cfg_pkg::way_mask_t desc_way_o,
  // Cache status and control
  input  logic                  quiescent_i,
  input  logic                  flush_done_i,
  output logic                  isolate_o,
  output llc_cfg_pkg::way_mask_t spm_lock_o,
  output llc_cfg_pkg::way_mask_t flushed_o
);
  import llc_cfg_pkg::*;

  // Registers to flush FSM
  way_mask_t cfg_spm;
  way_mask_t cfg_flush;
  way_mask_t flushed;
  logic      cfg_written;
  // Flush FSM to registers
  way_mask_t flushed_d;
  logic      flushed_load;
  logic      flush_clear;
  logic      cfg_busy;
  // Flush FSM to FIFO
  logic      push_valid;
  logic      push_ready;
  line_idx_t push_line;
  way_mask_t push_way;

  llc_cfg_regs i_regs (
    .rst_ni          (rst_ni),
    .reset_i         (reset_i),
    .reg_req_valid_i (reg_req_valid_i),
    .reg_req_ready_o (reg_req_ready_o),
    .reg_req_write_i (reg_req_write_i),
    .reg_req_addr_i  (reg_req_addr_i),
    .reg_req_wdata_i (reg_req_wdata_i),
    .reg_rsp_valid_o (reg_rsp_valid_o),
    .reg_rsp_ready_i (reg_rsp_ready_i),
    .reg_rsp_rdata_o (reg_rsp_rdata_o),
    .reg_rsp_err_o   (reg_rsp_err_o),
    .flushed_d_i     (flushed_d),
    .flushed_load_i  (flushed_load),
    .flush_clear_i   (flush_clear),
    .cfg_busy_i      (cfg_busy),
    .cfg_spm_o       (cfg_spm),
    .cfg_flush_o     (cfg_flush),
    .flushed_o       (flushed),
    .cfg_written_o   (cfg_written)
  );

  llc_flush_ctrl i_flush_ctrl (
    .rst_ni         (rst_ni),
    .reset_i        (reset_i),
    .cfg_written_i  (cfg_written),
    .cfg_spm_i      (cfg_spm),
    .cfg_flush_i    (cfg_flush),
    .flushed_i      (flushed),
    .flushed_d_o    (flushed_d),
    .flushed_load_o (flushed_load),
    .flush_clear_o  (flush_clear),
    .cfg_busy_o     (cfg_busy),
    .quiescent_i    (quiescent_i),
    .flush_done_i   (flush_done_i),
    .isolate_o      (isolate_o),
    .push_valid_o   (push_valid),
    .push_ready_i   (push_ready),
    .push_line_o    (push_line),
    .push_way_o     (push_way)
  );

  llc_flush_desc_fifo i_desc_fifo (
    .rst_ni       (rst_ni),
    .reset_i      (reset_i),
    .push_valid_i (push_valid),
    .push_ready_o (push_ready),
    .push_line_i  (push_line),
    .push_way_i   (push_way),
    .desc_valid_o (desc_valid_o),
    .desc_ready_i (desc_ready_i),
    .desc_index_o (desc_index_o),
    .desc_way_o   (desc_way_o)
  );

  // Cache-facing copies of the register state
  assign spm_lock_o = cfg_spm;
  assign flushed_o  = flushed;

endmodule

`default_nettype wire

//--- dv/tb_llc_cfg.sv
////////////////////////////////////////
// Cache model acks every descriptor once
// Ready inputs and ack delays come from an LFSR
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "llc_cfg_consts.svh"

module tb_llc_cfg;
  import llc_cfg_pkg::*;

  localparam int timeout_cycles = 2000;

  logic      rst_ni;
  logic      reset_i;
  logic      reg_req_valid_i;
  logic      reg_req_ready_o;
  logic      reg_req_write_i;
  reg_addr_t reg_req_addr_i;
  reg_data_t reg_req_wdata_i;
  logic      reg_rsp_valid_o;
  logic      reg_rsp_ready_i;
  reg_data_t reg_rsp_rdata_o;
  logic      reg_rsp_err_o;
  logic      desc_valid_o;
  logic      desc_ready_i;
  line_idx_t desc_index_o;
  way_mask_t desc_way_o;
  logic      quiescent_i;
  logic      flush_done_i;
  logic      isolate_o;
  way_mask_t spm_lock_o;
  way_mask_t flushed_o;

  int          errors;
  int          checks;
  logic [31:0] lfsr_q;
  // Cache model state
  int          pending;
  int          quiet_cnt;
  logic        iso_seen;
  int          iso_rises;
  way_mask_t   got_way[$];
  line_idx_t   got_idx[$];
  // Expected register contents
  way_mask_t   model_spm;
  way_mask_t   model_flush;
  way_mask_t   model_flushed;

  llc_cfg_top DUT (.*);

  always #5 rst_ni = ~rst_ni;

  // Galois LFSR, one step per bit taken
  function logic next_rand_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  ////////////////////////////////////////
  // Cache model and random back-pressure
  ////////////////////////////////////////
  always @(posedge rst_ni) begin
    if (reset_i) begin
      desc_ready_i    <= 1'b0;
      reg_rsp_ready_i <= 1'b0;
      flush_done_i    <= 1'b0;
      quiescent_i     <= 1'b0;
      quiet_cnt = 0;
    end else begin
      desc_ready_i    <= next_rand_bit() | next_rand_bit();
      reg_rsp_ready_i <= next_rand_bit() | next_rand_bit();
      // Quiet a few cycles after isolation starts
      if (!iso_seen) begin
        quiet_cnt = 0;
      end else if (quiet_cnt < 3) begin
        quiet_cnt++;
      end
      quiescent_i <= iso_seen && (quiet_cnt == 3);
      // One done pulse per taken descriptor, after a random gap
      if ((pending > 0) && next_rand_bit()) begin
        flush_done_i <= 1'b1;
        pending--;
      end else begin
        flush_done_i <= 1'b0;
      end
    end
  end

  // Mid-cycle sampling of DUT outputs
  always @(negedge rst_ni) begin
    if (!reset_i) begin
      if (isolate_o && !iso_seen) begin
        iso_rises++;
      end
      iso_seen = isolate_o;
      if (desc_valid_o && desc_ready_i) begin
        got_way.push_back(desc_way_o);
        got_idx.push_back(desc_index_o);
        pending++;
      end
    end
  end

  a_rsp_held: assert property (@(posedge rst_ni) disable iff (reset_i)
    (reg_rsp_valid_o && !reg_rsp_ready_i) |=>
      (reg_rsp_valid_o && $stable(reg_rsp_rdata_o) && $stable(reg_rsp_err_o)))
    else begin
      errors++;
      $display("register response changed or dropped while held");
    end

  a_desc_held: assert property (@(posedge rst_ni) disable iff (reset_i)
    (desc_valid_o && !desc_ready_i) |=>
      (desc_valid_o && $stable(desc_index_o) && $stable(desc_way_o)))
    else begin
      errors++;
      $display("descriptor changed or dropped under back-pressure");
    end

  // Descriptors only leave during isolation
  a_desc_isolated: assert property (@(posedge rst_ni) disable iff (reset_i)
    desc_valid_o |-> isolate_o)
    else begin
      errors++;
      $display("descriptor offered while isolate_o is low");
    end

  task automatic abort_run(input string what);
    $display("Timeout: %s", what);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    checks++;
    assert (act_v === exp_v) else begin
      errors++;
      $display("Fail %s expected %0h actual %0h", name, exp_v, act_v);
    end
  endtask

  // One request and its response
  task automatic reg_access(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                            output reg_data_t rdata, output logic err);
    int t;
    @(posedge rst_ni);
    reg_req_valid_i <= 1'b1;
    reg_req_write_i <= wr;
    reg_req_addr_i  <= addr;
    reg_req_wdata_i <= wdata;
    for (t = 0; t < timeout_cycles; t++) begin
      @(negedge rst_ni);
      if (reg_req_ready_o) break;
    end
    if (t == timeout_cycles) abort_run("register request never accepted");
    @(posedge rst_ni);
    reg_req_valid_i <= 1'b0;
    for (t = 0; t < timeout_cycles; t++) begin
      @(negedge rst_ni);
      if (reg_rsp_valid_o && reg_rsp_ready_i) break;
    end
    if (t == timeout_cycles) abort_run("register response never taken");
    rdata = reg_rsp_rdata_o;
    err   = reg_rsp_err_o;
    @(posedge rst_ni);
  endtask

  task automatic write_reg(input string name, input reg_addr_t addr, input reg_data_t wdata,
                           input logic exp_err);
    reg_data_t rdata;
    logic      err;
    reg_access(1'b1, addr, wdata, rdata, err);
    check_value({name, " write err"}, 32'(exp_err), 32'(err));
  endtask

  task automatic check_read(input string name, input reg_addr_t addr, input reg_data_t exp_data,
                            input logic exp_err);
    reg_data_t rdata;
    logic      err;
    reg_access(1'b0, addr, '0, rdata, err);
    check_value({name, " data"}, exp_data, rdata);
    check_value({name, " err"}, 32'(exp_err), 32'(err));
  endtask

  ////////////////////////////////////////
  // Config write plus full flush check
  ////////////////////////////////////////
  task automatic run_flush(input string name, input reg_addr_t addr, input way_mask_t wdata);
    way_mask_t mask;
    int        t;
    int        w;
    int        l;
    int        k;
    int        rises0;
    if (addr == reg_addr_t'(`LLC_REG_SPM)) model_spm = wdata;
    else model_flush = wdata;
    // Ways to flush and the resulting Flushed value
    if (|model_flush) begin
      mask = model_flush & ~model_flushed;
    end else begin
      mask          = model_spm & ~model_flushed;
      model_flushed = model_spm & model_flushed;
    end
    if (mask != '0) model_flushed = model_spm;
    model_flush = '0;
    got_way.delete();
    got_idx.delete();
    rises0 = iso_rises;
    write_reg(name, addr, reg_data_t'(wdata), 1'b0);
    for (t = 0; t < timeout_cycles; t++) begin
      @(negedge rst_ni);
      if (iso_rises != rises0) break;
    end
    if (t == timeout_cycles) abort_run("isolate_o never rose after a config write");
    for (t = 0; t < timeout_cycles; t++) begin
      @(negedge rst_ni);
      if (!isolate_o) break;
    end
    if (t == timeout_cycles) abort_run("flush sequence never finished");
    // Lowest way first, lines in ascending order
    check_value({name, " desc count"}, 32'($countones(mask) * `LLC_NUM_LINES),
                32'(got_way.size()));
    k = 0;
    for (w = 0; w < `LLC_SET_ASSO; w++) begin
      for (l = 0; l < `LLC_NUM_LINES; l++) begin
        if (mask[w] && (k < got_way.size())) begin
          check_value($sformatf("%s desc %0d way", name, k), 32'(1) << w, 32'(got_way[k]));
          check_value($sformatf("%s desc %0d line", name, k), 32'(l), 32'(got_idx[k]));
        end
        if (mask[w]) k++;
      end
    end
    check_read({name, " CfgSpm"}, reg_addr_t'(`LLC_REG_SPM), reg_data_t'(model_spm), 1'b0);
    check_read({name, " CfgFlush"}, reg_addr_t'(`LLC_REG_FLUSH), '0, 1'b0);
    check_read({name, " Flushed"}, reg_addr_t'(`LLC_REG_FLUSHED),
               reg_data_t'(model_flushed), 1'b0);
    check_value({name, " spm_lock_o"}, 32'(model_spm), 32'(spm_lock_o));
    check_value({name, " flushed_o"}, 32'(model_flushed), 32'(flushed_o));
  endtask

  initial begin
    rst_ni          = 1'b0;
    reset_i         = 1'b1;
    reg_req_valid_i = 1'b0;
    reg_req_write_i = 1'b0;
    reg_req_addr_i  = '0;
    reg_req_wdata_i = '0;
    reg_rsp_ready_i = 1'b0;
    desc_ready_i    = 1'b0;
    quiescent_i     = 1'b0;
    flush_done_i    = 1'b0;
    errors          = 0;
    checks          = 0;
    lfsr_q          = 32'hbb26;
    pending         = 0;
    quiet_cnt       = 0;
    iso_seen        = 1'b0;
    iso_rises       = 0;
    model_spm       = '0;
    model_flush     = '0;
    model_flushed   = '0;
    repeat (8) @(posedge rst_ni);
    reset_i <= 1'b0;
    @(negedge rst_ni);

    // Reset values
    check_value("reset isolate_o", 0, 32'(isolate_o));
    check_value("reset desc_valid_o", 0, 32'(desc_valid_o));
    check_value("reset reg_rsp_valid_o", 0, 32'(reg_rsp_valid_o));
    check_value("reset reg_req_ready_o", 1, 32'(reg_req_ready_o));
    check_read("reset SetAsso", reg_addr_t'(`LLC_REG_SET_ASSO), 32'd8, 1'b0);
    check_read("reset NumLines", reg_addr_t'(`LLC_REG_NUM_LINES), 32'd16, 1'b0);
    check_read("reset Version", reg_addr_t'(`LLC_REG_VERSION), `LLC_VERSION, 1'b0);
    check_read("reset CfgSpm", reg_addr_t'(`LLC_REG_SPM), '0, 1'b0);
    check_read("reset CfgFlush", reg_addr_t'(`LLC_REG_FLUSH), '0, 1'b0);
    check_read("reset Flushed", reg_addr_t'(`LLC_REG_FLUSHED), '0, 1'b0);

    // Explicit flush, then SPM setup and a repeated SPM write
    run_flush("flush_05", reg_addr_t'(`LLC_REG_FLUSH), 8'h05);
    run_flush("spm_82", reg_addr_t'(`LLC_REG_SPM), 8'h82);
    run_flush("spm_82_again", reg_addr_t'(`LLC_REG_SPM), 8'h82);

    // Read-only and unmapped indices
    write_reg("ro_flushed", reg_addr_t'(`LLC_REG_FLUSHED), 32'hff, 1'b1);
    check_read("ro_flushed", reg_addr_t'(`LLC_REG_FLUSHED), reg_data_t'(model_flushed), 1'b0);
    write_reg("ro_num_lines", reg_addr_t'(`LLC_REG_NUM_LINES), 32'h5, 1'b1);
    check_read("ro_num_lines", reg_addr_t'(`LLC_REG_NUM_LINES), 32'd16, 1'b0);
    check_read("unmapped_6", reg_addr_t'(6), '0, 1'b1);

    // Many ways under random back-pressure
    run_flush("flush_ff", reg_addr_t'(`LLC_REG_FLUSH), 8'hff);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/llc_cfg_pkg.sv
design/llc_cfg_regs.sv
design/llc_flush_ctrl.sv
design/llc_flush_desc_fifo.sv
design/llc_cfg_top.sv
dv/tb_llc_cfg.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_llc_cfg
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
